// File: flist.f
source/cnn_pkg.sv
source/row_window_buffer.sv
source/conv_relu_row.sv
source/max_pool_row.sv
source/dense_classifier.sv
source/cnn_top.sv
verif/tb_clock_gen.sv
verif/cnn_tb.sv

// File: Makefile
TOP_TB  = cnn_tb
TOP_RTL = cnn_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP_RTL) -f flist.f
	verilator --lint-only --timing --assert --top-module $(TOP_TB) -f flist.f

# the log decides pass or fail, since the simulator exits cleanly either way
sim:
	verilator --binary --timing --assert --top-module $(TOP_TB) -f flist.f -o sim_$(TOP_TB)
	./obj_dir/sim_$(TOP_TB) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/cnn_tb.sv
`timescale 1ns/1ps

module cnn_tb import cnn_pkg::*;;

	localparam int CLS_W       = $clog2(N_CLASS);
	localparam int N_FRAMES    = 20;
	localparam int TIMEOUT_CYC = N_FRAMES * 40 + 100;
	localparam int STROBE_LAT  = 6;
	localparam int STROBE_WAIT = 20;
	localparam logic [31:0] SEED = 32'h0953_052e;

	logic clk;
	logic resetn;
	logic [IMG_W*PIX_W-1:0] row_data_i;
	logic row_valid_i;
	logic [CLS_W-1:0] class_o;
	logic signed [SCORE_W-1:0] score_o;
	logic class_valid_o;

	logic [PIX_W-1:0] img [IMG_H][IMG_W];
	logic last_row;
	logic [CLS_W-1:0] exp_class;
	logic signed [SCORE_W-1:0] exp_score;
	int cyc = 0;
	int last_row_cyc = -100;
	int frames_sent = 0;
	int frames_done = 0;
	int class_errs = 0;
	int score_errs = 0;
	int timing_errs = 0;
	int other_errs = 0;

	tb_clock_gen u_clk_gen (.clk_o(clk), .resetn_o(resetn));

	cnn_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) UUT (
		.clk(clk), .resetn(resetn),
		.row_data_i(row_data_i), .row_valid_i(row_valid_i),
		.class_o(class_o), .score_o(score_o), .class_valid_o(class_valid_o)
	);

	// cycle count, frame bookkeeping and the run limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (row_valid_i && last_row) begin
			frames_sent <= frames_sent + 1;
			last_row_cyc <= cyc;
		end
		if (class_valid_o) begin
			frames_done <= frames_done + 1;
		end
		if (cyc >= TIMEOUT_CYC) begin
			$display("run stopped after %0d cycles without finishing the frames", cyc);
			$display("errors: class %0d, score %0d, timing %0d, other %0d",
				class_errs, score_errs, timing_errs, other_errs);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (!resetn)
		class_valid_o |-> class_o == exp_class)
	else begin
		class_errs++;
		$display("[ERROR] %0t class_o expected %0d got %0d", $time, exp_class, $sampled(class_o));
	end

	assert property (@(posedge clk) disable iff (!resetn)
		class_valid_o |-> score_o == exp_score)
	else begin
		score_errs++;
		$display("[ERROR] %0t score_o expected %0d got %0d", $time, exp_score, $sampled(score_o));
	end

	// nothing may come out before the first frame is in
	assert property (@(posedge clk) disable iff (!resetn)
		(frames_sent == 0) |-> !class_valid_o)
	else begin
		timing_errs++;
		$display("[ERROR] %0t class_valid_o high before any frame was delivered", $time);
	end

	assert property (@(posedge clk) disable iff (!resetn)
		class_valid_o |-> (frames_sent > frames_done) && (cyc == last_row_cyc + STROBE_LAT))
	else begin
		timing_errs++;
		$display("[ERROR] %0t class_valid_o strobe in cycle %0d, expected in cycle %0d",
			$time, $sampled(cyc), $sampled(last_row_cyc) + STROBE_LAT);
	end

	assert property (@(posedge clk) disable iff (!resetn)
		class_valid_o |=> !class_valid_o)
	else begin
		timing_errs++;
		$display("[ERROR] %0t class_valid_o held for more than one cycle", $time);
	end

	// modes 0 zero, 1 random, 2 all 255, 3 checkerboard, 4 inverted checkerboard
	task automatic fill_image(input int mode);
		for (int r = 0; r < IMG_H; r++) begin
			for (int c = 0; c < IMG_W; c++) begin
				case (mode)
					1: img[r][c] = PIX_W'($urandom);
					2: img[r][c] = '1;
					3: img[r][c] = ((r + c) % 2 == 1) ? '1 : '0;
					4: img[r][c] = ((r + c) % 2 == 1) ? '0 : '1;
					default: img[r][c] = '0;
				endcase
			end
		end
	endtask

	// integer model: padded 3x3 conv, shift, clamp, 2x2 max, dense, lowest index on a tie
	task automatic compute_expected();
		int conv [IMG_H][IMG_W][N_CH];
		int score [N_CLASS];
		int acc;
		int rr;
		int cc;
		int m;
		int best;
		for (int r = 0; r < IMG_H; r++) begin
			for (int c = 0; c < IMG_W; c++) begin
				for (int ch = 0; ch < N_CH; ch++) begin
					acc = 0;
					for (int kr = 0; kr < 3; kr++) begin
						for (int kc = 0; kc < 3; kc++) begin
							rr = r + kr - 1;
							cc = c + kc - 1;
							if (rr >= 0 && rr < IMG_H && cc >= 0 && cc < IMG_W) begin
								acc += int'(conv_weight(ch, kr, kc)) * int'(img[rr][cc]);
							end
						end
					end
					acc = acc >>> CONV_SHIFT;
					conv[r][c][ch] = (acc < 0) ? 0 : ((acc > 255) ? 255 : acc);
				end
			end
		end
		for (int k = 0; k < N_CLASS; k++) begin
			score[k] = int'(dense_bias(k));
			for (int pr = 0; pr < IMG_H / 2; pr++) begin
				for (int pc = 0; pc < IMG_W / 2; pc++) begin
					for (int ch = 0; ch < N_CH; ch++) begin
						m = 0;
						for (int d = 0; d < 4; d++) begin
							if (conv[2*pr + d/2][2*pc + d%2][ch] > m) begin
								m = conv[2*pr + d/2][2*pc + d%2][ch];
							end
						end
						score[k] += int'(dense_weight(k, ch, pr, pc)) * m;
					end
				end
			end
		end
		best = 0;
		for (int k = 1; k < N_CLASS; k++) begin
			if (score[k] > score[best]) begin
				best = k;
			end
		end
		exp_class = CLS_W'(best);
		exp_score = SCORE_W'(score[best]);
	endtask

	// rows on falling edges, then wait for the class strobe
	task automatic send_frame(input logic min_gap);
		int gap;
		int wait_cyc;
		for (int r = 0; r < IMG_H; r++) begin
			for (int c = 0; c < IMG_W; c++) begin
				row_data_i[c*PIX_W +: PIX_W] = img[r][c];
			end
			row_valid_i = 1'b1;
			last_row = (r == IMG_H - 1);
			@(negedge clk);
			row_valid_i = 1'b0;
			last_row = 1'b0;
			gap = min_gap ? 1 : int'($urandom_range(3, 1));
			if (r < IMG_H - 1) begin
				repeat (gap) @(negedge clk);
			end
		end
		wait_cyc = 0;
		while (!class_valid_o && wait_cyc < STROBE_WAIT) begin
			@(negedge clk);
			wait_cyc++;
		end
		if (!class_valid_o) begin
			other_errs++;
			$display("[ERROR] %0t no class strobe within %0d cycles of the last row",
				$time, STROBE_WAIT);
		end
		// let the strobe edge pass before the next frame's expectations
		@(negedge clk);
	endtask

	task automatic run_frame(input int mode, input logic min_gap);
		fill_image(mode);
		compute_expected();
		send_frame(min_gap);
	endtask

	initial begin
		row_data_i = '0;
		row_valid_i = 1'b0;
		last_row = 1'b0;
		exp_class = '0;
		exp_score = '0;
		void'($urandom(SEED));
		@(posedge resetn);
		// idle time after reset, class_valid_o must stay low
		repeat (6) @(negedge clk);

		// empty image leaves only the biases, 16 per class index
		fill_image(0);
		exp_class = CLS_W'(N_CLASS - 1);
		exp_score = SCORE_W'(16 * (N_CLASS - 1));
		send_frame(1'b0);

		repeat (16) begin
			run_frame(1, 1'b0);
		end
		// saturating and alternating images, back to back at the minimum gap
		run_frame(2, 1'b1);
		run_frame(3, 1'b1);
		run_frame(4, 1'b1);

		repeat (4) @(negedge clk);
		if (frames_done != N_FRAMES) begin
			other_errs++;
			$display("[ERROR] %0t expected %0d class strobes, saw %0d",
				$time, N_FRAMES, frames_done);
		end
		$display("errors: class %0d, score %0d, timing %0d, other %0d",
			class_errs, score_errs, timing_errs, other_errs);
		if (class_errs + score_errs + timing_errs + other_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 4
) (
	output logic clk_o,
	output logic resetn_o
);

	// 4 ns period
	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

	// release on a falling edge, clear of the sampling edge
	initial begin
		resetn_o = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_o);
		resetn_o = 1'b1;
	end

endmodule

// File: source/cnn_top.sv
`timescale 1ns/1ps

module cnn_top import cnn_pkg::*; #(
	parameter int IMG_W = cnn_pkg::IMG_W,
	parameter int IMG_H = cnn_pkg::IMG_H
) (
	input  logic                         clk,
	input  logic                         resetn,
	input  logic [IMG_W*PIX_W-1:0]       row_data_i,
	input  logic                         row_valid_i,
	output logic [$clog2(N_CLASS)-1:0]   class_o,
	output logic signed [SCORE_W-1:0]    score_o,
	output logic                         class_valid_o
);

	logic [(IMG_W+2)*PIX_W-1:0] win_top;
	logic [(IMG_W+2)*PIX_W-1:0] win_mid;
	logic [(IMG_W+2)*PIX_W-1:0] win_bot;
	logic win_valid;
	logic [IMG_W*N_CH*PIX_W-1:0] conv_row;
	logic conv_valid;
	logic [(IMG_W/2)*N_CH*PIX_W-1:0] pool_row;
	logic pool_valid;

	row_window_buffer #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_window (
		.clk(clk), .resetn(resetn),
		.row_data_i(row_data_i), .row_valid_i(row_valid_i),
		.win_top_o(win_top), .win_mid_o(win_mid), .win_bot_o(win_bot),
		.win_valid_o(win_valid)
	);

	conv_relu_row #(.IMG_W(IMG_W)) u_conv (
		.clk(clk), .resetn(resetn),
		.win_top_i(win_top), .win_mid_i(win_mid), .win_bot_i(win_bot),
		.win_valid_i(win_valid),
		.conv_row_o(conv_row), .conv_valid_o(conv_valid)
	);

	max_pool_row #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_pool (
		.clk(clk), .resetn(resetn),
		.conv_row_i(conv_row), .conv_valid_i(conv_valid),
		.pool_row_o(pool_row), .pool_valid_o(pool_valid)
	);

	dense_classifier #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_dense (
		.clk(clk), .resetn(resetn),
		.pool_row_i(pool_row), .pool_valid_i(pool_valid),
		.class_o(class_o), .score_o(score_o), .class_valid_o(class_valid_o)
	);

endmodule

// File: source/dense_classifier.sv
`timescale 1ns/1ps

module dense_classifier import cnn_pkg::*; #(
	parameter int IMG_W = cnn_pkg::IMG_W,
	parameter int IMG_H = cnn_pkg::IMG_H
) (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic [(IMG_W/2)*N_CH*PIX_W-1:0] pool_row_i,
	input  logic                            pool_valid_i,
	output logic [$clog2(N_CLASS)-1:0]      class_o,
	output logic signed [SCORE_W-1:0]       score_o,
	output logic                            class_valid_o
);

	localparam int PW    = IMG_W / 2;
	localparam int PH    = IMG_H / 2;
	localparam int PR_W  = $clog2(PH);
	localparam int CLS_W = $clog2(N_CLASS);

	dense_state_e state;
	logic [PR_W-1:0] pool_cnt;
	logic signed [SCORE_W-1:0] score [N_CLASS];
	logic signed [SCORE_W-1:0] row_sum [N_CLASS];
	logic [CLS_W-1:0] best_cls;
	logic signed [SCORE_W-1:0] best_score;

	// contribution of the current pooled row to every class
	always_comb begin
		int acc;
		for (int cls = 0; cls < N_CLASS; cls++) begin
			acc = 0;
			for (int pc = 0; pc < PW; pc++) begin
				for (int ch = 0; ch < N_CH; ch++) begin
					acc += int'(dense_weight(cls, ch, int'(pool_cnt), pc)) *
						int'(pool_row_i[(pc*N_CH + ch)*PIX_W +: PIX_W]);
				end
			end
			row_sum[cls] = SCORE_W'(acc);
		end
	end

	// strict compare keeps the lowest index on a tie
	always_comb begin
		best_cls = '0;
		best_score = score[0];
		for (int cls = 1; cls < N_CLASS; cls++) begin
			if (score[cls] > best_score) begin
				best_cls = CLS_W'(cls);
				best_score = score[cls];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
			pool_cnt <= '0;
			class_valid_o <= 1'b0;
		end else begin
			class_valid_o <= 1'b0;
			case (state)
				IDLE, ACCUM: begin
					if (pool_valid_i) begin
						if (pool_cnt == PR_W'(PH - 1)) begin
							pool_cnt <= '0;
							state <= DECIDE;
						end else begin
							pool_cnt <= pool_cnt + 1'b1;
							state <= ACCUM;
						end
					end
				end
				DECIDE: begin
					class_valid_o <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// first row of a frame starts from the bias
	always_ff @(posedge clk) begin
		for (int cls = 0; cls < N_CLASS; cls++) begin
			if (pool_valid_i) begin
				score[cls] <= ((state == IDLE) ? dense_bias(cls) : score[cls]) + row_sum[cls];
			end
		end
		if (state == DECIDE) begin
			class_o <= best_cls;
			score_o <= best_score;
		end
	end

	// upstream latency must leave the decide cycle free
	assert property (@(posedge clk) disable iff (!resetn)
		(state == DECIDE) |-> !pool_valid_i);

endmodule

// File: source/max_pool_row.sv
`timescale 1ns/1ps

module max_pool_row import cnn_pkg::*; #(
	parameter int IMG_W = cnn_pkg::IMG_W,
	parameter int IMG_H = cnn_pkg::IMG_H
) (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic [IMG_W*N_CH*PIX_W-1:0]     conv_row_i,
	input  logic                            conv_valid_i,
	output logic [(IMG_W/2)*N_CH*PIX_W-1:0] pool_row_o,
	output logic                            pool_valid_o
);

	localparam int CNT_W = $clog2(IMG_H);
	localparam int PW    = IMG_W / 2;

	logic [CNT_W-1:0] row_cnt;
	logic [IMG_W*N_CH*PIX_W-1:0] even_row;
	logic [PW*N_CH*PIX_W-1:0] pool_next;

	function automatic logic [PIX_W-1:0] max2(input logic [PIX_W-1:0] a,
			input logic [PIX_W-1:0] b);
		return (a > b) ? a : b;
	endfunction

	// 2x2 block max per channel, same index layout as the input
	always_comb begin
		logic [PIX_W-1:0] m_even;
		logic [PIX_W-1:0] m_odd;
		pool_next = '0;
		for (int p = 0; p < PW; p++) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				m_even = max2(even_row[((2*p)*N_CH + ch)*PIX_W +: PIX_W],
					even_row[((2*p + 1)*N_CH + ch)*PIX_W +: PIX_W]);
				m_odd = max2(conv_row_i[((2*p)*N_CH + ch)*PIX_W +: PIX_W],
					conv_row_i[((2*p + 1)*N_CH + ch)*PIX_W +: PIX_W]);
				pool_next[(p*N_CH + ch)*PIX_W +: PIX_W] = max2(m_even, m_odd);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_cnt <= '0;
			pool_valid_o <= 1'b0;
		end else begin
			pool_valid_o <= conv_valid_i & row_cnt[0];
			if (conv_valid_i) begin
				// wrap at frame end so parity restarts even
				row_cnt <= (row_cnt == CNT_W'(IMG_H - 1)) ? '0 : row_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (conv_valid_i) begin
			if (!row_cnt[0]) begin
				even_row <= conv_row_i;
			end else begin
				pool_row_o <= pool_next;
			end
		end
	end

endmodule

// File: source/conv_relu_row.sv
`timescale 1ns/1ps

module conv_relu_row import cnn_pkg::*; #(
	parameter int IMG_W = cnn_pkg::IMG_W
) (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic [(IMG_W+2)*PIX_W-1:0]    win_top_i,
	input  logic [(IMG_W+2)*PIX_W-1:0]    win_mid_i,
	input  logic [(IMG_W+2)*PIX_W-1:0]    win_bot_i,
	input  logic                          win_valid_i,
	output logic [IMG_W*N_CH*PIX_W-1:0]   conv_row_o,
	output logic                          conv_valid_o
);

	localparam int WIN_BITS = (IMG_W + 2) * PIX_W;
	localparam int PIX_MAX  = (1 << PIX_W) - 1;

	logic [WIN_BITS-1:0] win_rows [3];
	logic [IMG_W*N_CH*PIX_W-1:0] conv_next;

	// kernel row 0 sits on the top window row
	assign win_rows[0] = win_top_i;
	assign win_rows[1] = win_mid_i;
	assign win_rows[2] = win_bot_i;

	// feature (col c, ch) at index c*N_CH + ch
	always_comb begin
		int acc;
		conv_next = '0;
		for (int c = 0; c < IMG_W; c++) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				acc = 0;
				for (int kr = 0; kr < 3; kr++) begin
					for (int kc = 0; kc < 3; kc++) begin
						acc += int'(conv_weight(ch, kr, kc)) *
							int'(win_rows[kr][(c + kc)*PIX_W +: PIX_W]);
					end
				end
				acc = acc >>> CONV_SHIFT;
				// rectify, then saturate to a pixel
				if (acc < 0) begin
					acc = 0;
				end else if (acc > PIX_MAX) begin
					acc = PIX_MAX;
				end
				conv_next[(c*N_CH + ch)*PIX_W +: PIX_W] = acc[PIX_W-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			conv_valid_o <= 1'b0;
		end else begin
			conv_valid_o <= win_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid_i) begin
			conv_row_o <= conv_next;
		end
	end

endmodule

// File: source/row_window_buffer.sv
`timescale 1ns/1ps

module row_window_buffer import cnn_pkg::*; #(
	parameter int IMG_W = cnn_pkg::IMG_W,
	parameter int IMG_H = cnn_pkg::IMG_H
) (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic [IMG_W*PIX_W-1:0]     row_data_i,
	input  logic                       row_valid_i,
	output logic [(IMG_W+2)*PIX_W-1:0] win_top_o,
	output logic [(IMG_W+2)*PIX_W-1:0] win_mid_o,
	output logic [(IMG_W+2)*PIX_W-1:0] win_bot_o,
	output logic                       win_valid_o
);

	localparam int CNT_W = $clog2(IMG_H);
	localparam logic [PIX_W-1:0] ZPIX = '0;

	win_state_e state;
	logic [CNT_W-1:0] row_cnt;
	// the two most recent rows
	logic [IMG_W*PIX_W-1:0] line_old;
	logic [IMG_W*PIX_W-1:0] line_new;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= FILL;
			row_cnt <= '0;
			win_valid_o <= 1'b0;
		end else begin
			win_valid_o <= 1'b0;
			case (state)
				FILL: begin
					if (row_valid_i) begin
						row_cnt <= CNT_W'(1);
						state <= RUN;
					end
				end
				RUN: begin
					if (row_valid_i) begin
						win_valid_o <= 1'b1;
						if (row_cnt == CNT_W'(IMG_H - 1)) begin
							row_cnt <= '0;
							state <= FLUSH;
						end else begin
							row_cnt <= row_cnt + 1'b1;
						end
					end
				end
				// last window, bottom row is padding
				FLUSH: begin
					win_valid_o <= 1'b1;
					state <= FILL;
				end
				default: state <= FILL;
			endcase
		end
	end

	// left and right padding columns added on the way out
	always_ff @(posedge clk) begin
		if (state == FLUSH) begin
			win_top_o <= {ZPIX, line_old, ZPIX};
			win_mid_o <= {ZPIX, line_new, ZPIX};
			win_bot_o <= '0;
		end else if (row_valid_i) begin
			// zero top row for the first window
			line_old <= (state == FILL) ? '0 : line_new;
			line_new <= row_data_i;
			win_top_o <= {ZPIX, line_old, ZPIX};
			win_mid_o <= {ZPIX, line_new, ZPIX};
			win_bot_o <= {ZPIX, row_data_i, ZPIX};
		end
	end

	// rows need an idle cycle between them so the flush slot stays free
	assert property (@(posedge clk) disable iff (!resetn)
		row_valid_i |=> !row_valid_i);

endmodule

// File: source/cnn_pkg.sv
package cnn_pkg;

	localparam int PIX_W      = 8;
	localparam int IMG_W      = 8;
	localparam int IMG_H      = 8;
	localparam int N_CH       = 2;
	localparam int N_CLASS    = 4;
	localparam int CONV_SHIFT = 2;
	localparam int SCORE_W    = 20;

	typedef enum logic [1:0] {FILL, RUN, FLUSH} win_state_e;
	typedef enum logic [1:0] {IDLE, ACCUM, DECIDE} dense_state_e;

	// ch 0 is a vertical edge detector, ch 1 a smoothing kernel
	function automatic logic signed [3:0] conv_weight(input int ch, input int kr, input int kc);
		if (ch == 0) begin
			return 4'(kc - 1);
		end
		if (kr == 1 && kc == 1) begin
			return 4'sd2;
		end
		return 4'sd1;
	endfunction

	// index sum mod 5, centred on zero
	function automatic logic signed [3:0] dense_weight(input int cls, input int ch,
			input int pr, input int pc);
		int v;
		v = (cls + ch + pr + pc) % 5 - 2;
		return 4'(v);
	endfunction

	function automatic logic signed [SCORE_W-1:0] dense_bias(input int cls);
		return SCORE_W'(16 * cls);
	endfunction

endpackage
